//--- filelist.f
common/shim_pkg.sv
design/fault_encoder.sv
power_sequencer/power_sequencer.sv
design/status_latch.sv
design/shim_supervisor.sv
verif/shim_supervisor_assertions.sv
verif/tb_shim_supervisor.sv

//--- verif/tb_shim_supervisor.sv
`timescale 1ns/1ps
`default_nettype none

module tb_shim_supervisor;

  typedef enum logic [1:0] {PH_IDLE, PH_SPI, PH_RUN} phase_e; // When a row's faults go in

  typedef struct packed {
    phase_e                 phase;
    logic                   drop_en;  // Software shutdown while running
    logic                   spi_hang; // SPI never leaves its off state
    shim_pkg::cfg_checks_t  cfg;
    shim_pkg::boot_faults_t boot;
    shim_pkg::run_faults_t  run;
    shim_pkg::status_code_t exp_code;
    shim_pkg::board_num_t   exp_board;
  } row_t;

  localparam int WAIT_LIMIT      = 400; // Longest sequence is about 160 cycles
  localparam int SPI_BOOT_CYCLES = 20;

  logic                   clk;
  logic                   aresetn;
  logic                   sys_en;
  logic                   spi_off;
  shim_pkg::cfg_checks_t  cfg;
  shim_pkg::boot_faults_t boot;
  shim_pkg::run_faults_t  run;
  shim_pkg::power_ctrl_t  power;
  shim_pkg::status_word_t status_word;
  logic                   ps_interrupt;

  logic        spi_hang;
  int          spi_wait;
  int          cyc;
  int          irq_count;
  int          first_seen [5]; // Cycle of each power-up step or 0 until seen
  logic [4:0]  power_events;
  int          check_errors;
  int          timeout_errors;
  logic [31:0] lcg_state;
  row_t        rows [$];

  shim_supervisor uut (
    .clk          (clk),
    .aresetn      (aresetn),
    .sys_en       (sys_en),
    .spi_off      (spi_off),
    .cfg          (cfg),
    .boot         (boot),
    .run          (run),
    .power        (power),
    .status_word  (status_word),
    .ps_interrupt (ps_interrupt)
  );

  // Lock, force release, SPI enable, reset pulse and buffers open
  assign power_events = {!power.block_buffers, !power.n_shutdown_rst, power.spi_en,
                         power.n_shutdown_force, !power.unlock_cfg};

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // SPI subsystem model drops spi_off some cycles after spi_en
  always @(posedge clk) begin
    #1;
    if (!power.spi_en) begin
      spi_off  = 1'b1;
      spi_wait = 0;
    end else if (spi_wait < SPI_BOOT_CYCLES) begin
      spi_wait++;
    end else if (!spi_hang) begin
      spi_off = 1'b0;
    end
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Never empty so every fault names a board
  function automatic shim_pkg::board_mask_t rand_mask();
    logic [31:0]           r;
    shim_pkg::board_mask_t m;
    r = lcg_next();
    m = r[31:24]; // Upper bits spread better
    if (m == '0) m = 8'h80;
    return m;
  endfunction

  function automatic shim_pkg::board_num_t first_set_bit(shim_pkg::board_mask_t m);
    for (int i = 0; i < shim_pkg::NUM_BOARDS; i++) begin
      if (m[i]) return shim_pkg::board_num_t'(i);
    end
    return '0;
  endfunction

  function automatic shim_pkg::power_ctrl_t power_levels(logic unlock, logic clk_n, logic spi,
                                                         logic sense, logic block,
                                                         logic force_n, logic rst_n);
    shim_pkg::power_ctrl_t p;
    p.unlock_cfg        = unlock;
    p.spi_clk_power_n   = clk_n;
    p.spi_en            = spi;
    p.shutdown_sense_en = sense;
    p.block_buffers     = block;
    p.n_shutdown_force  = force_n;
    p.n_shutdown_rst    = rst_n;
    return p;
  endfunction

  function automatic shim_pkg::run_faults_t run_faults(logic lock, logic ext,
      shim_pkg::board_mask_t sense, shim_pkg::board_mask_t over, shim_pkg::board_mask_t under,
      shim_pkg::board_mask_t overf, shim_pkg::board_mask_t dac, shim_pkg::board_mask_t adc);
    shim_pkg::run_faults_t f;
    f.lock_viol        = lock;
    f.ext_shutdown     = ext;
    f.shutdown_sense   = sense;
    f.over_thresh      = over;
    f.thresh_underflow = under;
    f.thresh_overflow  = overf;
    f.bad_dac_cmd      = dac;
    f.bad_adc_cmd      = adc;
    return f;
  endfunction

  function automatic shim_pkg::seq_state_e cur_state();
    return shim_pkg::seq_state_e'(status_word[3:0]); // State in the low nibble
  endfunction

  task automatic check_code(string name, shim_pkg::status_code_t got,
                            shim_pkg::status_code_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0d ns: %s = %h, expected %h", $time, name, got, exp);
      check_errors++;
    end
  endtask

  task automatic check_board(string name, shim_pkg::board_num_t got, shim_pkg::board_num_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0d ns: %s = %0d, expected %0d", $time, name, got, exp);
      check_errors++;
    end
  endtask

  task automatic check_state(string name, shim_pkg::seq_state_e got, shim_pkg::seq_state_e exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0d ns: %s = %0d, expected %0d", $time, name, got, exp);
      check_errors++;
    end
  endtask

  task automatic check_power(string name, shim_pkg::power_ctrl_t got,
                             shim_pkg::power_ctrl_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0d ns: %s = %b, expected %b", $time, name, got, exp);
      check_errors++;
    end
  endtask

  task automatic check_count(string name, int got, int exp);
    if (got != exp) begin
      $display("CHECK FAILED at %0d ns: %s = %0d, expected %0d", $time, name, got, exp);
      check_errors++;
    end
  endtask

  task automatic finish_run();
    int assert_errors;
    assert_errors = uut.u_assertions.fail_count;
    $display("errors: %0d check, %0d timeout, %0d assertion",
             check_errors, timeout_errors, assert_errors);
    if (check_errors == 0 && timeout_errors == 0 && assert_errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  endtask

  // One cycle sampled where outputs are stable
  task automatic tick();
    @(posedge clk);
    #1;
    cyc++;
    if (ps_interrupt) irq_count++;
    for (int i = 0; i < 5; i++) begin
      if (power_events[i] && first_seen[i] == 0) first_seen[i] = cyc;
    end
  endtask

  task automatic wait_state(shim_pkg::seq_state_e s);
    int n;
    n = 0;
    while (cur_state() != s && n < WAIT_LIMIT) begin
      tick();
      n++;
    end
    if (cur_state() != s) begin
      $display("timeout at %0d ns: state %s never came", $time, s.name());
      timeout_errors++;
      finish_run();
    end
  endtask

  task automatic add_row(phase_e phase, logic drop_en, logic hang, shim_pkg::cfg_checks_t c,
                         shim_pkg::boot_faults_t b, shim_pkg::run_faults_t r,
                         shim_pkg::status_code_t code, shim_pkg::board_num_t board);
    row_t row;
    row.phase     = phase;
    row.drop_en   = drop_en;
    row.spi_hang  = hang;
    row.cfg       = c;
    row.boot      = b;
    row.run       = r;
    row.exp_code  = code;
    row.exp_board = board;
    rows.push_back(row);
  endtask

  // Idle to halt and back to idle
  task automatic run_row(row_t r);
    irq_count = 0;
    for (int i = 0; i < 5; i++) first_seen[i] = 0;
    spi_hang = r.spi_hang;
    if (r.phase == PH_IDLE) cfg = r.cfg;
    sys_en = 1'b1;
    if (r.phase == PH_SPI) begin
      wait_state(shim_pkg::SEQ_CONFIRM_SPI_START);
      boot = r.boot;
    end
    if (r.phase == PH_RUN) begin
      wait_state(shim_pkg::SEQ_RUNNING);
      check_power("power in run", power, power_levels(0, 0, 1, 1, 0, 1, 1));
      if (!(first_seen[0] > 0 && first_seen[0] < first_seen[1] &&
            first_seen[1] < first_seen[2] && first_seen[2] < first_seen[3] &&
            first_seen[3] < first_seen[4])) begin
        $display("power-up steps came out of order at %0d ns", $time);
        check_errors++;
      end
      run = r.run;
      if (r.drop_en) sys_en = 1'b0;
      repeat (2) tick(); // Input register then FSM
      check_state("state after fault", cur_state(), shim_pkg::SEQ_HALTING);
      tick();
      check_state("state after halting", cur_state(), shim_pkg::SEQ_HALTED);
    end else begin
      wait_state(shim_pkg::SEQ_HALTED);
    end
    if (r.phase == PH_IDLE && first_seen[1] != 0) begin
      $display("n_shutdown_force released despite a failed configuration check");
      check_errors++;
    end
    check_code("status code", status_word[28:4], r.exp_code);
    check_board("board number", status_word[31:29], r.exp_board);
    check_power("power after halt", power, power_levels(1, 1, 0, 0, 1, 0, 1));
    cfg      = '0;
    boot     = '0;
    run      = '0;
    sys_en   = 1'b0;
    spi_hang = 1'b0;
    wait_state(shim_pkg::SEQ_IDLE);
    repeat (2) tick();
    check_code("status code in idle", status_word[28:4], shim_pkg::STS_OK);
    check_board("board number in idle", status_word[31:29], '0);
    check_power("power in idle", power, power_levels(1, 1, 0, 0, 1, 0, 1));
    check_count("interrupt pulses", irq_count, (r.phase == PH_RUN) ? 2 : 1);
  endtask

  initial begin
    shim_pkg::board_mask_t m [12];
    lcg_state      = 32'd37386;
    aresetn        = 1'b0;
    sys_en         = 1'b0;
    spi_off        = 1'b1;
    cfg            = '0;
    boot           = '0;
    run            = '0;
    spi_hang       = 1'b0;
    spi_wait       = 0;
    cyc            = 0;
    irq_count      = 0;
    check_errors   = 0;
    timeout_errors = 0;
    repeat (3) tick();
    aresetn = 1'b1;
    tick();
    check_state("state after reset", cur_state(), shim_pkg::SEQ_IDLE);
    check_code("status code after reset", status_word[28:4], shim_pkg::STS_OK);
    check_board("board number after reset", status_word[31:29], '0);
    check_power("power after reset", power, power_levels(1, 1, 0, 0, 1, 0, 1));
    check_count("ps_interrupt after reset", int'(ps_interrupt), 0);

    for (int i = 0; i < 12; i++) m[i] = rand_mask();
    // cfg bits are thresh avg, window, integ en and sys en
    add_row(PH_RUN, 1'b1, 1'b0, '0, '0, '0, shim_pkg::STS_PS_SHUTDOWN, '0);
    add_row(PH_IDLE, 1'b0, 1'b0, 4'b0101, '0, '0, shim_pkg::STS_INTEG_WINDOW_OOB, '0);
    add_row(PH_IDLE, 1'b0, 1'b0, 4'b1011, '0, '0, shim_pkg::STS_INTEG_THRESH_AVG_OOB, '0);
    add_row(PH_IDLE, 1'b0, 1'b0, 4'b0011, '0, '0, shim_pkg::STS_INTEG_EN_OOB, '0);
    add_row(PH_RUN, 1'b0, 1'b0, '0, '0, run_faults(1, 0, m[0], '0, '0, '0, '0, '0),
            shim_pkg::STS_LOCK_VIOL, '0);
    add_row(PH_RUN, 1'b0, 1'b0, '0, '0, run_faults(0, 1, m[1], m[2], '0, '0, '0, '0),
            shim_pkg::STS_SHUTDOWN_SENSE, first_set_bit(m[1]));
    add_row(PH_RUN, 1'b0, 1'b0, '0, '0, run_faults(0, 1, '0, m[3], '0, '0, '0, '0),
            shim_pkg::STS_EXT_SHUTDOWN, '0);
    add_row(PH_RUN, 1'b0, 1'b0, '0, '0, run_faults(0, 0, '0, m[4], m[5], '0, m[6], '0),
            shim_pkg::STS_OVER_THRESH, first_set_bit(m[4]));
    add_row(PH_RUN, 1'b0, 1'b0, '0, '0, run_faults(0, 0, '0, '0, m[5], m[7], '0, '0),
            shim_pkg::STS_THRESH_UNDERFLOW, first_set_bit(m[5]));
    add_row(PH_RUN, 1'b0, 1'b0, '0, '0, run_faults(0, 0, '0, '0, '0, m[7], '0, m[8]),
            shim_pkg::STS_THRESH_OVERFLOW, first_set_bit(m[7]));
    add_row(PH_RUN, 1'b0, 1'b0, '0, '0, run_faults(0, 0, '0, '0, '0, '0, m[6], m[8]),
            shim_pkg::STS_BAD_DAC_CMD, first_set_bit(m[6]));
    add_row(PH_RUN, 1'b0, 1'b0, '0, '0, run_faults(0, 0, '0, '0, '0, '0, '0, m[9]),
            shim_pkg::STS_BAD_ADC_CMD, first_set_bit(m[9]));
    add_row(PH_SPI, 1'b0, 1'b0, '0, {m[10], m[11]}, '0,
            shim_pkg::STS_DAC_BOOT_FAIL, first_set_bit(m[10]));
    add_row(PH_SPI, 1'b0, 1'b0, '0, {8'h00, m[11]}, '0,
            shim_pkg::STS_ADC_BOOT_FAIL, first_set_bit(m[11]));
    add_row(PH_SPI, 1'b0, 1'b1, '0, '0, '0, shim_pkg::STS_SPI_START_TIMEOUT, '0);

    foreach (rows[i]) run_row(rows[i]);
    finish_run();
  end

endmodule

`default_nettype wire

//--- verif/shim_supervisor_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module shim_supervisor_assertions (
  input wire                         clk,
  input wire                         aresetn,
  input wire shim_pkg::power_ctrl_t  power,
  input wire shim_pkg::status_word_t status_word,
  input wire                         ps_interrupt
);

  int fail_count = 0; // Failed assertions so far

  // Interrupt is a one-cycle strobe
  irq_single_cycle: assert property (@(posedge clk) disable iff (!aresetn)
    ps_interrupt |=> !ps_interrupt)
    else begin
      $error("ps_interrupt held high for two cycles");
      fail_count++;
    end

  // SPI may only talk once shutdown force is released
  spi_needs_force_release: assert property (@(posedge clk) disable iff (!aresetn)
    power.spi_en |-> power.n_shutdown_force)
    else begin
      $error("spi_en high while n_shutdown_force is low");
      fail_count++;
    end

  // Halted means buffers blocked and config open
  halted_is_safe: assert property (@(posedge clk) disable iff (!aresetn)
    (status_word[3:0] == shim_pkg::SEQ_HALTED) |-> (power.block_buffers && power.unlock_cfg))
    else begin
      $error("halted with buffers open or configuration locked");
      fail_count++;
    end

endmodule

bind shim_supervisor shim_supervisor_assertions u_assertions (
  .clk          (clk),
  .aresetn      (aresetn),
  .power        (power),
  .status_word  (status_word),
  .ps_interrupt (ps_interrupt)
);

`default_nettype wire

//--- design/shim_supervisor.sv
`timescale 1ns/1ps
`default_nettype none

module shim_supervisor (
  input  wire                          clk,
  input  wire                          aresetn,
  input  wire                          sys_en,
  input  wire                          spi_off,
  input  wire shim_pkg::cfg_checks_t   cfg,
  input  wire shim_pkg::boot_faults_t  boot,
  input  wire shim_pkg::run_faults_t   run,
  output shim_pkg::power_ctrl_t        power,
  output shim_pkg::status_word_t       status_word,
  output logic                         ps_interrupt
);

  logic                    sys_en_q;
  logic                    spi_off_q;
  shim_pkg::fault_report_t cfg_report;
  shim_pkg::fault_report_t boot_report;
  shim_pkg::fault_report_t run_report;
  shim_pkg::seq_state_e    state;
  shim_pkg::fault_report_t halt_cause;
  logic                    notify;     // Entered RUNNING or HALTED
  logic                    clear;      // Back to idle

  // Stage 1 registers and ranks the fault inputs
  fault_encoder u_fault_encoder (
    .clk         (clk),
    .aresetn     (aresetn),
    .sys_en      (sys_en),
    .spi_off     (spi_off),
    .cfg         (cfg),
    .boot        (boot),
    .run         (run),
    .sys_en_q    (sys_en_q),
    .spi_off_q   (spi_off_q),
    .cfg_report  (cfg_report),
    .boot_report (boot_report),
    .run_report  (run_report)
  );

  // Stage 2 power-up and halt FSM
  power_sequencer u_power_sequencer (
    .clk         (clk),
    .aresetn     (aresetn),
    .sys_en_q    (sys_en_q),
    .spi_off_q   (spi_off_q),
    .cfg_report  (cfg_report),
    .boot_report (boot_report),
    .run_report  (run_report),
    .state       (state),
    .power       (power),
    .halt_cause  (halt_cause),
    .notify      (notify),
    .clear       (clear)
  );

  // Stage 3 status word and interrupt
  status_latch u_status_latch (
    .clk          (clk),
    .aresetn      (aresetn),
    .state        (state),
    .halt_cause   (halt_cause),
    .notify       (notify),
    .clear        (clear),
    .status_word  (status_word),
    .ps_interrupt (ps_interrupt)
  );

endmodule

`default_nettype wire

//--- design/status_latch.sv
`timescale 1ns/1ps
`default_nettype none

module status_latch (
  input  wire                          clk,
  input  wire                          aresetn,
  input  wire shim_pkg::seq_state_e    state,
  input  wire shim_pkg::fault_report_t halt_cause,
  input  wire                          notify,
  input  wire                          clear,
  output shim_pkg::status_word_t       status_word,
  output logic                         ps_interrupt
);

  shim_pkg::status_code_t status_code; // Last halt reason
  shim_pkg::board_num_t   board_num;

  // Code and board persist through HALTED until the return to idle
  always_ff @(posedge clk) begin
    if (!aresetn) begin
      status_code <= shim_pkg::STS_OK;
      board_num   <= '0;
    end else if (clear) begin
      status_code <= shim_pkg::STS_OK;
      board_num   <= '0;
    end else if (halt_cause.valid) begin
      status_code <= halt_cause.code;
      board_num   <= halt_cause.board;
    end
  end

  // One cycle behind notify
  always_ff @(posedge clk) begin
    if (!aresetn) begin
      ps_interrupt <= 1'b0;
    end else begin
      ps_interrupt <= notify;
    end
  end

  // Board in the top bits, state in the bottom nibble
  assign status_word = {board_num, status_code, state};

endmodule

`default_nettype wire

//--- power_sequencer/power_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module power_sequencer (
  input  wire                          clk,
  input  wire                          aresetn,
  input  wire                          sys_en_q,
  input  wire                          spi_off_q,
  input  wire shim_pkg::fault_report_t cfg_report,
  input  wire shim_pkg::fault_report_t boot_report,
  input  wire shim_pkg::fault_report_t run_report,
  output shim_pkg::seq_state_e         state,
  output shim_pkg::power_ctrl_t        power,
  output shim_pkg::fault_report_t      halt_cause,
  output logic                         notify,
  output logic                         clear
);

  shim_pkg::delay_count_t timer; // Shared by all timed states

  // Leaving HALTED for IDLE this cycle
  assign clear = (state == shim_pkg::SEQ_HALTED) && !sys_en_q;

  always_ff @(posedge clk) begin
    if (!aresetn) begin
      state      <= shim_pkg::SEQ_IDLE;
      timer      <= '0;
      power      <= shim_pkg::PWR_SAFE;
      halt_cause <= '{valid: 1'b0, code: shim_pkg::STS_OK, board: '0};
      notify     <= 1'b0;
    end else begin
      halt_cause.valid <= 1'b0; // Only high for the HALTING cycle
      notify           <= 1'b0; // Strobe
      case (state)

        // Wait for enable and check configuration before touching power
        shim_pkg::SEQ_IDLE: begin
          if (sys_en_q) begin
            timer <= '0;
            if (cfg_report.valid) begin
              state      <= shim_pkg::SEQ_HALTING;
              halt_cause <= cfg_report;
            end else begin
              state                 <= shim_pkg::SEQ_CONFIRM_SPI_RST;
              power.unlock_cfg      <= 1'b0; // Lock configuration
              power.spi_clk_power_n <= 1'b0; // Clock on for reset check
            end
          end
        end

        // SPI subsystem has to come up in its off state
        shim_pkg::SEQ_CONFIRM_SPI_RST: begin
          if (timer >= shim_pkg::SPI_RESET_MIN && spi_off_q) begin
            state                  <= shim_pkg::SEQ_POWER_ON_CTRL;
            timer                  <= '0;
            power.spi_clk_power_n  <= 1'b1;
            power.n_shutdown_force <= 1'b1; // Release shutdown force
          end else if (timer >= shim_pkg::SPI_RESET_WAIT) begin
            state            <= shim_pkg::SEQ_HALTING;
            halt_cause.valid <= 1'b1;
            halt_cause.code  <= shim_pkg::STS_SPI_RESET_TIMEOUT;
            halt_cause.board <= '0;
          end else begin
            timer <= timer + 1'b1;
          end
        end

        // Let DAC and ADC power up before SPI starts talking
        shim_pkg::SEQ_POWER_ON_CTRL: begin
          if (timer >= shim_pkg::SHUTDOWN_FORCE_DELAY) begin
            state                   <= shim_pkg::SEQ_CONFIRM_SPI_START;
            timer                   <= '0;
            power.shutdown_sense_en <= 1'b1;
            power.spi_clk_power_n   <= 1'b0;
            power.spi_en            <= 1'b1;
          end else begin
            timer <= timer + 1'b1;
          end
        end

        // SPI start wins over boot faults seen in the same cycle
        shim_pkg::SEQ_CONFIRM_SPI_START: begin
          if (!spi_off_q) begin
            state                <= shim_pkg::SEQ_POWER_ON_AMP;
            timer                <= '0;
            power.n_shutdown_rst <= 1'b0; // Start reset pulse
          end else if (boot_report.valid) begin
            state      <= shim_pkg::SEQ_HALTING;
            timer      <= '0;
            halt_cause <= boot_report;
          end else if (timer >= shim_pkg::SPI_START_WAIT) begin
            state            <= shim_pkg::SEQ_HALTING;
            timer            <= '0;
            halt_cause.valid <= 1'b1;
            halt_cause.code  <= shim_pkg::STS_SPI_START_TIMEOUT;
            halt_cause.board <= '0;
          end else begin
            timer <= timer + 1'b1;
          end
        end

        shim_pkg::SEQ_POWER_ON_AMP: begin
          if (timer >= shim_pkg::SHUTDOWN_RESET_PULSE) begin
            state                <= shim_pkg::SEQ_AMP_POWER_WAIT;
            timer                <= '0;
            power.n_shutdown_rst <= 1'b1; // End of pulse
          end else begin
            timer <= timer + 1'b1;
          end
        end

        shim_pkg::SEQ_AMP_POWER_WAIT: begin
          if (timer >= shim_pkg::SHUTDOWN_RESET_DELAY) begin
            state               <= shim_pkg::SEQ_RUNNING;
            timer               <= '0;
            power.block_buffers <= 1'b0; // Open command and data paths
            notify              <= 1'b1;
          end else begin
            timer <= timer + 1'b1;
          end
        end

        // Every running cycle is checked
        shim_pkg::SEQ_RUNNING: begin
          if (run_report.valid) begin
            state      <= shim_pkg::SEQ_HALTING;
            halt_cause <= run_report;
          end
        end

        shim_pkg::SEQ_HALTING: begin
          state  <= shim_pkg::SEQ_HALTED;
          timer  <= '0;
          power  <= shim_pkg::PWR_SAFE; // All outputs back to safe levels
          notify <= 1'b1;
        end

        // Stay here until software drops enable
        shim_pkg::SEQ_HALTED: begin
          if (!sys_en_q) begin
            state <= shim_pkg::SEQ_IDLE;
          end
        end

        default: begin // Corrupt state register
          state            <= shim_pkg::SEQ_HALTING;
          timer            <= '0;
          halt_cause.valid <= 1'b1;
          halt_cause.code  <= shim_pkg::STS_OK;
          halt_cause.board <= '0;
        end

      endcase
    end
  end

endmodule

`default_nettype wire

//--- design/fault_encoder.sv
`timescale 1ns/1ps
`default_nettype none

module fault_encoder (
  input  wire                    clk,
  input  wire                    aresetn,
  input  wire                    sys_en,
  input  wire                    spi_off,
  input  wire shim_pkg::cfg_checks_t  cfg,
  input  wire shim_pkg::boot_faults_t boot,
  input  wire shim_pkg::run_faults_t  run,
  output logic                   sys_en_q,
  output logic                   spi_off_q,
  output shim_pkg::fault_report_t cfg_report,
  output shim_pkg::fault_report_t boot_report,
  output shim_pkg::fault_report_t run_report
);

  shim_pkg::cfg_checks_t  cfg_q;
  shim_pkg::boot_faults_t boot_q;
  shim_pkg::run_faults_t  run_q;

  // Input capture, all reports share this one stage
  always_ff @(posedge clk) begin
    if (!aresetn) begin
      sys_en_q  <= 1'b0;
      spi_off_q <= 1'b0;
      cfg_q     <= '0;
      boot_q    <= '0;
      run_q     <= '0;
    end else begin
      sys_en_q  <= sys_en;
      spi_off_q <= spi_off;
      cfg_q     <= cfg;
      boot_q    <= boot;
      run_q     <= run;
    end
  end

  // Configuration checks, board-less
  always_comb begin
    cfg_report.valid = 1'b1;
    cfg_report.board = '0;
    if (cfg_q.integ_thresh_avg_oob)  cfg_report.code = shim_pkg::STS_INTEG_THRESH_AVG_OOB;
    else if (cfg_q.integ_window_oob) cfg_report.code = shim_pkg::STS_INTEG_WINDOW_OOB;
    else if (cfg_q.integ_en_oob)     cfg_report.code = shim_pkg::STS_INTEG_EN_OOB;
    else if (cfg_q.sys_en_oob)       cfg_report.code = shim_pkg::STS_SYS_EN_OOB;
    else begin
      cfg_report.valid = 1'b0; // Nothing wrong
      cfg_report.code  = shim_pkg::STS_OK;
    end
  end

  // DAC boot ranks above ADC boot
  always_comb begin
    boot_report.valid = 1'b1;
    if (|boot_q.dac_boot_fail) begin
      boot_report.code  = shim_pkg::STS_DAC_BOOT_FAIL;
      boot_report.board = shim_pkg::lowest_board(boot_q.dac_boot_fail);
    end else if (|boot_q.adc_boot_fail) begin
      boot_report.code  = shim_pkg::STS_ADC_BOOT_FAIL;
      boot_report.board = shim_pkg::lowest_board(boot_q.adc_boot_fail);
    end else begin
      boot_report.valid = 1'b0;
      boot_report.code  = shim_pkg::STS_OK;
      boot_report.board = '0;
    end
  end

  // Run faults, software shutdown first
  always_comb begin
    run_report.valid = 1'b1;
    run_report.board = '0; // Single-bit causes report board 0
    if (!sys_en_q) begin
      run_report.code = shim_pkg::STS_PS_SHUTDOWN;
    end else if (run_q.lock_viol) begin
      run_report.code = shim_pkg::STS_LOCK_VIOL;
    end else if (|run_q.shutdown_sense) begin
      run_report.code  = shim_pkg::STS_SHUTDOWN_SENSE;
      run_report.board = shim_pkg::lowest_board(run_q.shutdown_sense);
    end else if (run_q.ext_shutdown) begin
      run_report.code = shim_pkg::STS_EXT_SHUTDOWN;
    end else if (|run_q.over_thresh) begin
      run_report.code  = shim_pkg::STS_OVER_THRESH;
      run_report.board = shim_pkg::lowest_board(run_q.over_thresh);
    end else if (|run_q.thresh_underflow) begin
      run_report.code  = shim_pkg::STS_THRESH_UNDERFLOW;
      run_report.board = shim_pkg::lowest_board(run_q.thresh_underflow);
    end else if (|run_q.thresh_overflow) begin
      run_report.code  = shim_pkg::STS_THRESH_OVERFLOW;
      run_report.board = shim_pkg::lowest_board(run_q.thresh_overflow);
    end else if (|run_q.bad_dac_cmd) begin
      run_report.code  = shim_pkg::STS_BAD_DAC_CMD;
      run_report.board = shim_pkg::lowest_board(run_q.bad_dac_cmd);
    end else if (|run_q.bad_adc_cmd) begin
      run_report.code  = shim_pkg::STS_BAD_ADC_CMD;
      run_report.board = shim_pkg::lowest_board(run_q.bad_adc_cmd);
    end else begin
      run_report.valid = 1'b0;
      run_report.code  = shim_pkg::STS_OK;
    end
  end

endmodule

`default_nettype wire

//--- common/shim_pkg.sv
`default_nettype none

package shim_pkg;

  localparam int NUM_BOARDS = 8; // Amplifier boards in the chassis

  // Widths with a meaning
  typedef logic [NUM_BOARDS-1:0] board_mask_t; // One flag per board
  typedef logic [2:0]            board_num_t;
  typedef logic [24:0]           status_code_t;
  typedef logic [31:0]           delay_count_t; // Sequencer timer
  typedef logic [31:0]           status_word_t; // {board, code, state}

  // Fixed encodings that software decodes from the status word
  typedef enum logic [3:0] {
    SEQ_IDLE              = 4'd1,
    SEQ_CONFIRM_SPI_RST   = 4'd2,
    SEQ_POWER_ON_CTRL     = 4'd3,
    SEQ_CONFIRM_SPI_START = 4'd4,
    SEQ_POWER_ON_AMP      = 4'd5,
    SEQ_AMP_POWER_WAIT    = 4'd6,
    SEQ_RUNNING           = 4'd7,
    SEQ_HALTING           = 4'd8,
    SEQ_HALTED            = 4'd9
  } seq_state_e;

  // Basic system
  localparam status_code_t STS_OK                   = 25'h0001;
  localparam status_code_t STS_PS_SHUTDOWN          = 25'h0002; // sys_en dropped in run
  // SPI subsystem
  localparam status_code_t STS_SPI_RESET_TIMEOUT    = 25'h0100;
  localparam status_code_t STS_SPI_START_TIMEOUT    = 25'h0101;
  // Configuration checks
  localparam status_code_t STS_INTEG_THRESH_AVG_OOB = 25'h0200;
  localparam status_code_t STS_INTEG_WINDOW_OOB     = 25'h0201;
  localparam status_code_t STS_INTEG_EN_OOB         = 25'h0202;
  localparam status_code_t STS_SYS_EN_OOB           = 25'h0203;
  localparam status_code_t STS_LOCK_VIOL            = 25'h0204;
  // Shutdown sense
  localparam status_code_t STS_SHUTDOWN_SENSE       = 25'h0300;
  localparam status_code_t STS_EXT_SHUTDOWN         = 25'h0301;
  // Integrator threshold core
  localparam status_code_t STS_OVER_THRESH          = 25'h0400;
  localparam status_code_t STS_THRESH_UNDERFLOW     = 25'h0401;
  localparam status_code_t STS_THRESH_OVERFLOW      = 25'h0402;
  // DAC and ADC
  localparam status_code_t STS_DAC_BOOT_FAIL        = 25'h0600;
  localparam status_code_t STS_BAD_DAC_CMD          = 25'h0601;
  localparam status_code_t STS_ADC_BOOT_FAIL        = 25'h0700;
  localparam status_code_t STS_BAD_ADC_CMD          = 25'h0701;

  // Sequencer delays in clk cycles
  localparam delay_count_t SPI_RESET_MIN        = 32'd10;  // Earliest SPI-off pass
  localparam delay_count_t SPI_RESET_WAIT       = 32'd100; // SPI-off timeout
  localparam delay_count_t SHUTDOWN_FORCE_DELAY = 32'd40;  // Control board settle
  localparam delay_count_t SPI_START_WAIT       = 32'd100; // SPI start timeout
  localparam delay_count_t SHUTDOWN_RESET_PULSE = 32'd8;   // n_shutdown_rst low width
  localparam delay_count_t SHUTDOWN_RESET_DELAY = 32'd40;  // Amp settle before run

  // Checked once at enable
  typedef struct packed {
    logic integ_thresh_avg_oob;
    logic integ_window_oob;
    logic integ_en_oob;
    logic sys_en_oob;
  } cfg_checks_t;

  // Watched while waiting for SPI start
  typedef struct packed {
    board_mask_t dac_boot_fail;
    board_mask_t adc_boot_fail;
  } boot_faults_t;

  // Watched every running cycle
  typedef struct packed {
    logic        lock_viol;
    logic        ext_shutdown;
    board_mask_t shutdown_sense;
    board_mask_t over_thresh;
    board_mask_t thresh_underflow;
    board_mask_t thresh_overflow;
    board_mask_t bad_dac_cmd;
    board_mask_t bad_adc_cmd;
  } run_faults_t;

  typedef struct packed {
    logic         valid;
    status_code_t code;
    board_num_t   board;
  } fault_report_t;

  typedef struct packed {
    logic unlock_cfg;
    logic spi_clk_power_n;   // Active low
    logic spi_en;
    logic shutdown_sense_en;
    logic block_buffers;
    logic n_shutdown_force;  // Active low
    logic n_shutdown_rst;    // Active low
  } power_ctrl_t;

  // Power outputs at reset and after a halt
  localparam power_ctrl_t PWR_SAFE = '{
    unlock_cfg:        1'b1,
    spi_clk_power_n:   1'b1,
    spi_en:            1'b0,
    shutdown_sense_en: 1'b0,
    block_buffers:     1'b1,
    n_shutdown_force:  1'b0,
    n_shutdown_rst:    1'b1
  };

  // Index of lowest set bit or 0 when none
  function automatic board_num_t lowest_board(board_mask_t mask);
    board_num_t idx;
    idx = '0;
    for (int i = NUM_BOARDS - 1; i >= 0; i--) begin
      if (mask[i]) idx = board_num_t'(i); // Lower bits overwrite higher ones
    end
    return idx;
  endfunction

endpackage

`default_nettype wire
